// File: include/config.svh
`ifndef CONFIG_SVH
`define CONFIG_SVH

// Panel keys and LEDs are ORed with the board ones
`define TM1638_DUPLICATE_KEYS 1

// Panel wiring expects segments in hgfedcba order
`define TM1638_REVERSE_SEGMENTS 1

// Panel geometry
`define TM1638_W_KEY 8
`define TM1638_W_LED 8

`endif

// File: hdl/board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------
    // Display and counter payloads

    typedef logic [7:0] seg_t;    // abcdefgh, bit 7 is segment a
    typedef logic [3:0] count_t;  // One hex digit

    typedef struct packed {
        logic tick;               // Shared sample strobe
        logic level;              // Synchronized key level
    } key_lane_t;

    typedef struct packed {
        count_t count;            // Presses modulo 16
        logic   pressed;          // Debounced key level
    } lane_status_t;

    // ------------------------------
    // TM1638 command bytes

    localparam logic [7:0] tm_cmd_write_auto = 8'h40;  // Write, auto increment
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;
    localparam logic [7:0] tm_cmd_addr0      = 8'hC0;  // Start at display address 0
    localparam logic [7:0] tm_cmd_display_on = 8'h8F;  // Display on, full brightness

    // Equal samples needed before a new key level is accepted
    localparam int debounce_samples = 4;

endpackage

`default_nettype wire

// File: hdl/key_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module key_sampler
#(
    parameter clk_mhz   = 50,
              sample_us = 1000,
              w_key     = 8
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [w_key - 1:0]                 key,
    output board_pkg::key_lane_t [w_key - 1:0] lanes
);

    import board_pkg::*;

    localparam int period = clk_mhz * sample_us;  // Cycles per sample
    localparam int w_div  = $clog2(period + 1);

    logic [w_key - 1:0] key_meta;
    logic [w_key - 1:0] key_sync;
    logic [w_div - 1:0] div_cnt;
    logic               tick;

    always_ff @(posedge clk)
        if (reset)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= key;       // Keys are asynchronous
            key_sync <= key_meta;
        end

    // Sample strobe divider
    always_ff @(posedge clk)
        if (reset)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else
        begin
            div_cnt <= (div_cnt == w_div'(period - 1)) ? '0 : div_cnt + 1'b1;
            tick    <= (div_cnt == w_div'(period - 1));
        end

    for (genvar i = 0; i < w_key; i++)
    begin : lane_out
        assign lanes[i] = key_lane_t'{tick: tick, level: key_sync[i]};
    end

    // Strobe is a single-cycle pulse
    tick_single_cycle: assert property (@(posedge clk) disable iff (reset) tick |=> !tick);

endmodule

`default_nettype wire

// File: hdl/key_press_counter.sv
`timescale 1ns/1ps
`default_nettype none

module key_press_counter
(
    input  logic                    clk,
    input  logic                    reset,
    input  board_pkg::key_lane_t    lane,
    output board_pkg::lane_status_t status
);

    import board_pkg::*;

    localparam int w_run = $clog2(debounce_samples + 1);

    logic               level_q;  // Accepted key level
    logic [w_run - 1:0] run_q;    // Samples differing from level_q
    count_t             count_q;
    logic               differs;
    logic               accept;

    assign differs = (lane.level != level_q);
    assign accept  = lane.tick && differs && (run_q == w_run'(debounce_samples - 1));

    // ------------------------------
    // Debounce

    always_ff @(posedge clk)
        if (reset)
        begin
            level_q <= 1'b0;
            run_q   <= '0;
        end
        else if (lane.tick)
        begin
            if (!differs)
                run_q <= '0;          // Glitch ended, start over
            else if (accept)
            begin
                level_q <= lane.level;
                run_q   <= '0;
            end
            else
                run_q <= run_q + 1'b1;
        end

    // Press counter, wraps at 16
    always_ff @(posedge clk)
        if (reset)
            count_q <= '0;
        else if (accept && lane.level)
            count_q <= count_q + 1'b1;

    assign status = lane_status_t'{count: count_q, pressed: level_q};

    count_follows_tick: assert property (@(posedge clk) disable iff (reset)
        !$stable(count_q) |-> $past(lane.tick));

endmodule

`default_nettype wire

// File: hdl/digit_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module digit_scanner
#(
    parameter w_lane  = 8,
              w_digit = 8,   // At least 2
              w_led   = 8
)
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   tick,
    input  board_pkg::lane_status_t [w_lane - 1:0] status,
    output board_pkg::seg_t                        abcdefgh,
    output logic [w_digit - 1:0]                   digit,
    output logic [w_led   - 1:0]                   led
);

    import board_pkg::*;

    localparam int n_shown = w_digit < w_lane ? w_digit : w_lane;

    count_t sel_count;
    logic   sel_valid;

    function automatic seg_t hex_glyph(input count_t value);
        case (value)
            4'h0:    hex_glyph = 8'b1111_1100;
            4'h1:    hex_glyph = 8'b0110_0000;
            4'h2:    hex_glyph = 8'b1101_1010;
            4'h3:    hex_glyph = 8'b1111_0010;
            4'h4:    hex_glyph = 8'b0110_0110;
            4'h5:    hex_glyph = 8'b1011_0110;
            4'h6:    hex_glyph = 8'b1011_1110;
            4'h7:    hex_glyph = 8'b1110_0000;
            4'h8:    hex_glyph = 8'b1111_1110;
            4'h9:    hex_glyph = 8'b1111_0110;
            4'hA:    hex_glyph = 8'b1110_1110;
            4'hB:    hex_glyph = 8'b0011_1110;  // Lower case b
            4'hC:    hex_glyph = 8'b1001_1100;
            4'hD:    hex_glyph = 8'b0111_1010;  // Lower case d
            4'hE:    hex_glyph = 8'b1001_1110;
            default: hex_glyph = 8'b1000_1110;
        endcase
    endfunction

    // One-hot scan, one digit per tick
    always_ff @(posedge clk)
        if (reset)
            digit <= w_digit'(1);
        else if (tick)
            digit <= {digit[w_digit - 2:0], digit[w_digit - 1]};

    always_comb
    begin
        sel_count = '0;
        sel_valid = 1'b0;

        for (int i = 0; i < n_shown; i++)
            if (digit[i])
            begin
                sel_count = status[i].count;
                sel_valid = 1'b1;
            end
    end

    assign abcdefgh = sel_valid ? hex_glyph(sel_count) : '0;  // Blank past the last lane

    for (genvar i = 0; i < w_led; i++)
    begin : led_drive
        if (i < w_lane)
        begin : used
            assign led[i] = status[i].pressed;
        end
        else
        begin : unused
            assign led[i] = 1'b0;
        end
    end

    digit_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(digit));

endmodule

`default_nettype wire

// File: hdl/top.sv
`timescale 1ns/1ps
`default_nettype none

module top
#(
    parameter clk_mhz   = 50,
              sample_us = 1000,
              w_key     = 8,
              w_led     = 8,
              w_digit   = 8
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [w_key   - 1:0]   key,
    output board_pkg::seg_t        abcdefgh,
    output logic [w_digit - 1:0]   digit,
    output logic [w_led   - 1:0]   led
);

    import board_pkg::*;

    key_lane_t    [w_key - 1:0] lanes;   // Sampler to counters
    lane_status_t [w_key - 1:0] status;  // Counters to scanner

    key_sampler
    #(
        .clk_mhz   ( clk_mhz   ),
        .sample_us ( sample_us ),
        .w_key     ( w_key     )
    )
    i_sampler
    (
        .clk   ( clk   ),
        .reset ( reset ),
        .key   ( key   ),
        .lanes ( lanes )
    );

    for (genvar i = 0; i < w_key; i++)
    begin : lane
        key_press_counter i_counter
        (
            .clk    ( clk       ),
            .reset  ( reset     ),
            .lane   ( lanes[i]  ),
            .status ( status[i] )
        );
    end

    digit_scanner
    #(
        .w_lane  ( w_key   ),
        .w_digit ( w_digit ),
        .w_led   ( w_led   )
    )
    i_scanner
    (
        .clk      ( clk           ),
        .reset    ( reset         ),
        .tick     ( lanes[0].tick ),  // All lanes share one strobe
        .status   ( status        ),
        .abcdefgh ( abcdefgh      ),
        .digit    ( digit         ),
        .led      ( led           )
    );

endmodule

`default_nettype wire

// File: hdl/tm1638_board_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_board_controller
#(
    parameter clk_mhz = 50,
              w_digit = 8,   // Up to 8
              w_led   = 8    // Up to 8
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  board_pkg::seg_t      hgfedcba,
    input  logic [w_digit - 1:0] digit,
    input  logic [w_led   - 1:0] ledr,
    output logic [          7:0] keys,
    output logic                 sio_clk,
    output logic                 sio_stb,
    inout  wire                  sio_data
);

    import board_pkg::*;

    localparam int half_period = clk_mhz / 2 > 1 ? clk_mhz / 2 : 1;
    localparam int w_timer     = $clog2(half_period + 1);

    typedef enum logic [1:0] { P_WRITE, P_DATA, P_DISPLAY, P_READ } phase_t;
    typedef enum logic [1:0] { S_GAP, S_HIGH, S_LOW, S_LAST } state_t;

    seg_t                 digit_buf [8];
    logic [7:0]           led_all;
    state_t               state;
    phase_t               phase;
    logic [4:0]           byte_idx;
    logic [2:0]           bit_idx;
    logic [w_timer - 1:0] timer;
    logic                 step;
    logic [7:0]           tx_byte;
    logic [4:0]           last_byte;
    logic                 reading;
    logic [7:0]           rx_full;
    logic [7:0]           rx_shift;
    logic [7:0]           key_acc;
    logic [7:0]           key_next;
    logic                 data_out;
    logic                 data_oe;

    // ------------------------------
    // Display buffer

    always_ff @(posedge clk)
        if (reset)
            for (int i = 0; i < 8; i++)
                digit_buf[i] <= '0;
        else
            for (int i = 0; i < w_digit; i++)
                if (digit[i])
                    digit_buf[i] <= hgfedcba;

    assign led_all = 8'(ledr);

    // ------------------------------
    // Frame contents

    always_comb
    begin
        logic [3:0] slot;

        slot    = 4'(byte_idx - 5'd1);
        tx_byte = 8'h00;

        case (phase)
            P_WRITE:   tx_byte = tm_cmd_write_auto;
            P_DATA:
            begin
                if (byte_idx == 5'd0)
                    tx_byte = tm_cmd_addr0;
                else if (!slot[0])
                    tx_byte = digit_buf[slot[3:1]];         // Even address, segments
                else
                    tx_byte = {7'd0, led_all[slot[3:1]]};  // Odd address, LED
            end
            P_DISPLAY: tx_byte = tm_cmd_display_on;
            default:   tx_byte = (byte_idx == 5'd0) ? tm_cmd_read_keys : 8'h00;
        endcase
    end

    assign last_byte = (phase == P_DATA) ? 5'd16 : (phase == P_READ) ? 5'd4 : 5'd0;
    assign reading   = (phase == P_READ) && (byte_idx != 5'd0);

    // Byte b bit 0 is key b, bit 4 is key b + 4
    always_comb
    begin
        logic [1:0] rb;

        rb       = 2'(byte_idx - 5'd1);
        rx_full  = {sio_data, rx_shift[7:1]};
        key_next = key_acc;
        key_next[{1'b0, rb}] = rx_full[0];
        key_next[{1'b1, rb}] = rx_full[4];
    end

    // ------------------------------
    // Serial engine

    assign step = (timer == '0);

    always_ff @(posedge clk)
        if (reset)
        begin
            state    <= S_GAP;
            phase    <= P_WRITE;
            byte_idx <= '0;
            bit_idx  <= '0;
            timer    <= '0;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            data_oe  <= 1'b0;
            keys     <= '0;
        end
        else
        begin
            timer <= step ? w_timer'(half_period - 1) : timer - 1'b1;

            if (step)
                case (state)
                    S_GAP:
                        sio_stb <= 1'b0;
                    S_HIGH:
                    begin
                        sio_clk  <= 1'b0;
                        data_out <= tx_byte[bit_idx];
                        data_oe  <= !reading;              // Released for key bytes
                        state    <= S_LOW;
                    end
                    S_LOW:
                    begin
                        sio_clk <= 1'b1;                  // Panel and controller sample
                        if (reading)
                            rx_shift <= rx_full;
                        if (reading && bit_idx == 3'd7)
                            key_acc <= key_next;
                        if (bit_idx == 3'd7 && byte_idx == last_byte)
                            state <= S_LAST;
                        else
                        begin
                            state   <= S_HIGH;
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == 3'd7)
                                byte_idx <= byte_idx + 1'b1;
                        end
                    end
                    default:
                    begin
                        sio_stb  <= 1'b1;
                        data_oe  <= 1'b0;
                        byte_idx <= '0;
                        bit_idx  <= '0;
                        phase    <= phase_t'(phase + 2'd1);
                        state    <= S_GAP;
                        if (phase == P_READ)
                            keys <= key_acc;              // Once per frame
                    end
                endcase

            if (step && state == S_GAP)
                state <= S_HIGH;
        end

    assign sio_data = data_oe ? data_out : 1'bz;

    clk_idle_high: assert property (@(posedge clk) disable iff (reset) sio_stb |-> sio_clk);

endmodule

`default_nettype wire

// File: hdl/board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module board_specific_top
#(
    parameter clk_mhz   = 50,
              sample_us = 1000,
              w_key     = 2,
              w_led     = 6,
              w_digit   = 8,
              w_gpio    = 23
)
(
    input  logic                CLK,
    input  logic                reset,
    input  logic [w_key  - 1:0] KEY,     // Active low
    output logic [w_led  - 1:0] LED,     // Active low
    inout  wire  [w_gpio - 1:0] GPIO
);

    import board_pkg::*;

    // ------------------------------
    // Widths

    localparam w_tm_key      = `TM1638_W_KEY,
               w_tm_led      = `TM1638_W_LED,
               w_tm_digit    = w_digit,
               w_board_digit = 0;   // On-board digits are not used

    localparam w_top_key   = w_tm_key   > w_key         ? w_tm_key   : w_key,
               w_top_led   = w_tm_led   > w_led         ? w_tm_led   : w_led,
               w_top_digit = w_tm_digit > w_board_digit ? w_tm_digit : w_board_digit;

    generate
        if (`TM1638_DUPLICATE_KEYS == 0)
        begin : mode_check
            $error("Only the duplicate key mode is supported");
        end
    endgenerate

    logic [w_key       - 1:0] board_key;
    logic [w_tm_key    - 1:0] tm_key;
    logic [w_top_key   - 1:0] top_key;
    logic [w_top_led   - 1:0] top_led;
    logic [w_top_digit - 1:0] top_digit;
    seg_t                     abcdefgh;
    seg_t                     hgfedcba;

    // ------------------------------
    // Key and LED merge

    assign board_key = ~KEY;
    assign top_key   = w_top_key'(board_key) | w_top_key'(tm_key);

    assign LED = ~top_led[w_led - 1:0];

    top
    #(
        .clk_mhz   ( clk_mhz     ),
        .sample_us ( sample_us   ),
        .w_key     ( w_top_key   ),
        .w_led     ( w_top_led   ),
        .w_digit   ( w_top_digit )
    )
    i_top
    (
        .clk      ( CLK       ),
        .reset    ( reset     ),
        .key      ( top_key   ),
        .abcdefgh ( abcdefgh  ),
        .digit    ( top_digit ),
        .led      ( top_led   )
    );

    // ------------------------------
    // Segment order for the panel

    for (genvar i = 0; i < $bits(seg_t); i++)
    begin : seg_order
        assign hgfedcba[i] = `TM1638_REVERSE_SEGMENTS ? abcdefgh[$bits(seg_t) - 1 - i]
                                                      : abcdefgh[i];
    end

    tm1638_board_controller
    #(
        .clk_mhz ( clk_mhz    ),
        .w_digit ( w_tm_digit ),
        .w_led   ( w_tm_led   )
    )
    i_tm1638
    (
        .clk      ( CLK                        ),
        .reset    ( reset                      ),
        .hgfedcba ( hgfedcba                   ),
        .digit    ( top_digit[w_tm_digit - 1:0] ),
        .ledr     ( top_led[w_tm_led - 1:0]     ),
        .keys     ( tm_key                     ),
        .sio_clk  ( GPIO[15]                   ),
        .sio_stb  ( GPIO[14]                   ),
        .sio_data ( GPIO[16]                   )
    );

    assign GPIO[13:0]          = '0;  // Unused header pins
    assign GPIO[w_gpio - 1:17] = '0;

endmodule

`default_nettype wire

// File: tb/tm1638_panel_model.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_panel_model
(
    input  wire             sio_clk,
    input  wire             sio_stb,
    inout  wire             sio_data,
    input  logic [7:0]      keys,
    output logic [7:0][7:0] seg,      // Digit bytes as received, hgfedcba
    output logic [7:0]      led,
    output logic [15:0]     frames    // Frames that ended with a full key read
);

    import board_pkg::*;

    logic [7:0]  ram [16] = '{default: 8'h00};
    logic [7:0]  shift     = '0;
    logic [15:0] frame_cnt = '0;
    int          bit_cnt   = 0;
    int          byte_cnt  = 0;
    int          rd_bit    = 0;
    int          addr      = 0;
    logic        reading   = 1'b0;
    logic        writing   = 1'b0;
    logic        drive_en  = 1'b0;
    logic        drive_bit = 1'b0;
    logic        clk_q     = 1'b1;
    logic        stb_q     = 1'b1;

    // Byte b bit 0 is key b, bit 4 is key b + 4
    function automatic logic key_bit(input int n);
        int b;
        int k;
        b = n / 8;
        k = n % 8;
        if (k == 0)
            return keys[b];
        else if (k == 4)
            return keys[b + 4];
        return 1'b0;
    endfunction

    task automatic take_byte(input logic [7:0] b);
        if (byte_cnt == 0)
        begin
            if (b == tm_cmd_read_keys)
                reading = 1'b1;
            else if (b[7:6] == tm_cmd_addr0[7:6])
            begin
                writing = 1'b1;              // Address command, data bytes follow
                addr    = int'(b[3:0]);
            end
        end
        else if (writing)
        begin
            ram[addr] = b;
            addr      = (addr + 1) % 16;     // Auto increment
        end
        byte_cnt++;
    endtask

    // ------------------------------
    // Serial decode, one process for both pins

    always @(sio_clk or sio_stb)
    begin
        if (stb_q === 1'b1 && sio_stb === 1'b0)
        begin
            bit_cnt  = 0;
            byte_cnt = 0;
            rd_bit   = 0;
            reading  = 1'b0;
            writing  = 1'b0;
        end
        if (stb_q === 1'b0 && sio_stb === 1'b1)
        begin
            if (reading && rd_bit == 32)
                frame_cnt = frame_cnt + 1'b1;
            reading  = 1'b0;
            drive_en = 1'b0;
        end
        if (sio_stb === 1'b0 && clk_q === 1'b0 && sio_clk === 1'b1)
        begin
            if (reading)
                rd_bit++;                        // Controller samples this edge
            else
            begin
                shift = {sio_data, shift[7:1]};  // LSB first
                bit_cnt++;
                if (bit_cnt == 8)
                begin
                    take_byte(shift);
                    bit_cnt = 0;
                end
            end
        end
        if (sio_stb === 1'b0 && clk_q === 1'b1 && sio_clk === 1'b0 && reading)
        begin
            drive_en  = (rd_bit < 32);
            drive_bit = key_bit(rd_bit);
        end
        clk_q = sio_clk;
        stb_q = sio_stb;
    end

    for (genvar i = 0; i < 8; i++)
    begin : panel_out
        assign seg[i] = ram[2 * i];
        assign led[i] = ram[2 * i + 1][0];
    end

    assign frames   = frame_cnt;
    assign sio_data = drive_en ? drive_bit : 1'bz;

endmodule

`default_nettype wire

// File: tb/tb_board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_specific_top;

    import board_pkg::*;

    localparam int clk_mhz      = 10;
    localparam int sample_us    = 10;
    localparam int half_period  = clk_mhz / 2 > 1 ? clk_mhz / 2 : 1;
    localparam int frame_cycles = (192 + 16) * 2 * half_period;  // 192 bits and phase gaps
    localparam int tick_cycles  = clk_mhz * sample_us;
    localparam int settle       = 4;    // Frames from key change to the shown result
    localparam int n_random     = 12;
    localparam int n_board      = 4;
    localparam int n_glitch     = 8;
    localparam int n_wrap       = 17;
    localparam int run_frames   = (n_random + n_board + n_wrap) * 2 * settle
                                + n_glitch * settle + 3 * 2 + 20;
    localparam longint watchdog_ns = longint'(run_frames) * frame_cycles * 100;

    logic            clk;
    logic            reset;
    logic [1:0]      key_n;
    logic [5:0]      led_n;
    wire  [22:0]     gpio;
    logic [7:0]      panel_keys;
    logic [7:0][7:0] panel_seg;
    logic [7:0]      panel_led;
    logic [15:0]     frames;

    count_t          exp_count [8];   // Presses per key, modulo 16
    logic [7:0]      exp_seg   [8];
    logic [7:0]      exp_led;
    logic            chk_display;
    logic            chk_stb;
    int              errors;
    int              errors_at_start;
    int              tests_run;
    int              tests_failed;

    board_specific_top #(.clk_mhz(clk_mhz), .sample_us(sample_us)) u_dut
    (
        .CLK   ( clk   ),
        .reset ( reset ),
        .KEY   ( key_n ),
        .LED   ( led_n ),
        .GPIO  ( gpio  )
    );

    pullup (gpio[16]);

    tm1638_panel_model i_panel
    (
        .sio_clk  ( gpio[15]   ),
        .sio_stb  ( gpio[14]   ),
        .sio_data ( gpio[16]   ),
        .keys     ( panel_keys ),
        .seg      ( panel_seg  ),
        .led      ( panel_led  ),
        .frames   ( frames     )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Expected values

    function automatic string lit_segments(input count_t value);
        case (value)
            4'h0:    return "abcdef";
            4'h1:    return "bc";
            4'h2:    return "abdeg";
            4'h3:    return "abcdg";
            4'h4:    return "bcfg";
            4'h5:    return "acdfg";
            4'h6:    return "acdefg";
            4'h7:    return "abc";
            4'h8:    return "abcdefg";
            4'h9:    return "abcdfg";
            4'hA:    return "abcefg";
            4'hB:    return "cdefg";
            4'hC:    return "adef";
            4'hD:    return "bcdeg";
            4'hE:    return "adefg";
            default: return "aefg";
        endcase
    endfunction

    function automatic logic [7:0] panel_pattern(input count_t value);
        string      s;
        logic [7:0] p;
        s = lit_segments(value);
        p = '0;
        for (int i = 0; i < s.len(); i++)
            p[s[i] - "a"] = 1'b1;       // Panel order puts segment a in bit 0
        return p;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("CHECK FAILED at %0d ns: %s = 'h%0h, expected 'h%0h",
                 $time, name, got, want);
    endtask

    // ------------------------------
    // Checks

    for (genvar i = 0; i < 8; i++)
    begin : display_checks
        digit_shown: assert property (@(posedge clk) chk_display |-> panel_seg[i] == exp_seg[i])
            else report_mismatch($sformatf("panel digit %0d", i), $sampled(panel_seg[i]),
                                 $sampled(exp_seg[i]));
        led_shown: assert property (@(posedge clk) chk_display |-> panel_led[i] == exp_led[i])
            else report_mismatch($sformatf("panel LED %0d", i), {7'd0, $sampled(panel_led[i])},
                                 {7'd0, $sampled(exp_led[i])});
    end

    board_led_shown: assert property (@(posedge clk) chk_display |-> led_n == ~exp_led[5:0])
        else report_mismatch("LED", {2'b00, $sampled(led_n)}, {2'b00, ~$sampled(exp_led[5:0])});

    // Header pins outside the panel bus
    gpio_unused_low: assert property (@(posedge clk)
                                      chk_display |-> {gpio[22:17], gpio[13:0]} === 20'd0)
        else report_mismatch("GPIO unused pins",
                             {12'd0, $sampled(gpio[22:17]), $sampled(gpio[13:0])}, 32'd0);

    stb_released: assert property (@(posedge clk) chk_stb |-> gpio[14] === 1'b1)
        else report_mismatch("sio_stb", {7'd0, $sampled(gpio[14])}, 8'd1);

    // ------------------------------
    // Stimulus

    task automatic wait_frames(input int n);
        logic [15:0] start;
        start = frames;
        wait (16'(frames - start) >= 16'(n));   // Watchdog bounds this
        @(negedge clk);
    endtask

    task automatic check_display();
        for (int i = 0; i < 8; i++)
            exp_seg[i] = panel_pattern(exp_count[i]);
        chk_display = 1'b1;
        @(negedge clk);
        chk_display = 1'b0;
    endtask

    task automatic press(input logic [7:0] panel_mask, input logic [1:0] board_mask);
        logic [7:0] held;
        held       = panel_mask | {6'd0, board_mask};
        panel_keys = panel_keys | panel_mask;
        key_n      = key_n & ~board_mask;
        wait_frames(settle);
        for (int i = 0; i < 8; i++)
            if (held[i])
                exp_count[i] = exp_count[i] + 1'b1;
        exp_led = held;
        check_display();
        panel_keys = panel_keys & ~panel_mask;
        key_n      = key_n | board_mask;
        wait_frames(settle);
        exp_led = '0;
        check_display();
    endtask

    // Board key low for fewer ticks than the debounce window
    task automatic glitch(input int b);
        key_n[b] = 1'b0;
        repeat ((debounce_samples - 1) * tick_cycles) @(negedge clk);
        key_n[b] = 1'b1;
        wait_frames(settle);
        check_display();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        chk_stb = 1'b1;
        @(negedge clk);
        chk_stb = 1'b0;
        repeat (13) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 8; i++)
            exp_count[i] = '0;
        exp_led = '0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_at_start)
        begin
            tests_failed++;
            $display("test %-14s failed", name);
        end
        else
            $display("test %-14s passed", name);
        errors_at_start = errors;
    endtask

    initial
    begin
        int k;
        reset           = 1'b1;
        key_n           = '1;
        panel_keys      = '0;
        exp_led         = '0;
        chk_display     = 1'b0;
        chk_stb         = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        for (int i = 0; i < 8; i++)
            exp_count[i] = '0;
        void'($urandom(32'h0b37_1b71));

        @(negedge clk);
        apply_reset();
        wait_frames(2);
        check_display();
        end_test("reset_state");

        for (int n = 0; n < n_random; n++)
            press(8'd1 << ($urandom % 8), 2'b00);
        end_test("panel_keys");

        press(8'h00, 2'b01);
        press(8'h00, 2'b10);
        press(8'h01, 2'b01);   // Same key from both sources counts once
        press(8'h02, 2'b10);
        end_test("board_keys");

        for (int n = 0; n < n_glitch; n++)
            glitch(n % 2);
        end_test("glitch");

        apply_reset();
        wait_frames(2);
        check_display();
        end_test("mid_run_reset");

        k = $urandom % 8;
        for (int n = 0; n < n_wrap; n++)
            press(8'd1 << k, 2'b00);
        end_test("wrap");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/board_pkg.sv
hdl/key_sampler.sv
hdl/key_press_counter.sv
hdl/digit_scanner.sv
hdl/top.sv
hdl/tm1638_board_controller.sv
hdl/board_specific_top.sv
tb/tm1638_panel_model.sv
tb/tb_board_specific_top.sv

// File: Bender.yml
package:
  name: tm1638_front_panel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/board_pkg.sv
      - hdl/key_sampler.sv
      - hdl/key_press_counter.sv
      - hdl/digit_scanner.sv
      - hdl/top.sv
      - hdl/tm1638_board_controller.sv
      - hdl/board_specific_top.sv
  - target: simulation
    files:
      - tb/tm1638_panel_model.sv
      - tb/tb_board_specific_top.sv
